// ==== all.f ====
src/uart_cmd_pkg.sv
src/uart_char_decoder.sv
src/hex_word_assembler.sv
src/monitor_cmd_fsm.sv
src/uart_cmd_top.sv
tb/uart_cmd_checker.sv
tb/tb_uart_cmd.sv

// ==== run.sh ====
#!/bin/sh
# build and run the command parser testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_uart_cmd -f all.f &&
./obj_dir/Vtb_uart_cmd +verilator+error+limit+100 | tee /dev/stderr | grep -q "^Simulation passed$" ||
{ echo "testbench run did not pass"; exit 1; }

// ==== tb/tb_uart_cmd.sv ====
// command parser testbench
`timescale 1ns/1ps

module tb_uart_cmd;

	localparam int start_delay = 3;
	localparam time period = 40ns;
	// upper bound on bytes sent, five cycles each
	localparam int byte_budget = 120;
	localparam int margin_cycles = 400;
	// rising edges per strobe over the whole run, cpu_start first
	localparam int expected_pulses [13] = '{1, 1, 2, 2, 2, 1, 1, 4, 1, 1, 1, 1, 13};

	logic                clk;
	logic                rst_n;
	uart_cmd_pkg::char_t rout;
	logic                rout_en;
	logic                dump_running;
	logic                trash_running;
	logic                dcflush_running;
	uart_cmd_pkg::word_t uart_data;
	logic                cpu_start;
	logic                write_address_set;
	logic                write_data_en;
	logic                read_start_set;
	logic                read_end_set;
	logic                read_stop;
	logic                start_trash;
	logic                quit_cmd;
	logic                inst_address_set;
	logic                inst_data_en;
	logic                pc_print;
	logic                pc_print_sel;
	logic                crlf_in;

	// reference model state
	int                   errors = 0;
	int                   cyc = 0;
	int                   go_sample = -100;
	int                   pulses [13];
	logic [12:0]          prev_s;
	uart_cmd_pkg::state_t m_state;
	logic                 m_en;
	uart_cmd_pkg::char_t  m_byte;
	logic [63:0]          m_chars;
	int                   m_cnt;
	logic                 m_wv;
	uart_cmd_pkg::word_t  m_data;
	// outputs captured mid-cycle
	logic [12:0]          out_s;
	uart_cmd_pkg::word_t  out_data;
	string names [13] = '{"cpu_start", "write_address_set", "write_data_en", "read_start_set",
		"read_end_set", "read_stop", "start_trash", "quit_cmd", "inst_address_set",
		"inst_data_en", "pc_print", "pc_print_sel", "crlf_in"};

	uart_cmd_top #(
		.start_delay (start_delay)
	) u_dut (.*);

	bind monitor_cmd_fsm uart_cmd_checker #(
		.start_delay (start_delay)
	) u_checker (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.cmd        (cmd),
		.word_valid (word_valid),
		.crlf_in    (crlf_in),
		.cpu_start  (cpu_start),
		.strobes    ({write_address_set, write_data_en, read_start_set, read_end_set,
			read_stop, start_trash, quit_cmd, inst_address_set, inst_data_en, pc_print, crlf_in})
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// eight hex characters, first one sent is the top nibble
	function automatic uart_cmd_pkg::word_t expected_word(input logic [63:0] chars);
		uart_cmd_pkg::word_t w;
		uart_cmd_pkg::char_t ch;
		w = '0;
		for (int i = 7; i >= 0; i--) begin
			ch = chars[i*8 +: 8];
			if (ch <= uart_cmd_pkg::ch_nine) begin
				w = {w[27:0], 4'(ch - uart_cmd_pkg::ch_zero)};
			end else begin
				w = {w[27:0], 4'(ch - uart_cmd_pkg::ch_a_low + 8'd10)};
			end
		end
		return w;
	endfunction

	function automatic logic is_hex(input uart_cmd_pkg::char_t ch);
		return (ch >= uart_cmd_pkg::ch_zero && ch <= uart_cmd_pkg::ch_nine)
			|| (ch >= uart_cmd_pkg::ch_a_low && ch <= uart_cmd_pkg::ch_f_low);
	endfunction

	function automatic uart_cmd_pkg::char_t hex_char(input uart_cmd_pkg::nibble_t n);
		if (n < 4'd10) begin
			return uart_cmd_pkg::ch_zero + 8'(n);
		end
		return uart_cmd_pkg::ch_a_low + 8'(n) - 8'd10;
	endfunction

	// where a letter leads from idle
	function automatic uart_cmd_pkg::state_t idle_target(input uart_cmd_pkg::char_t ch);
		case (ch)
			uart_cmd_pkg::ch_j: return uart_cmd_pkg::st_pc_print;
			uart_cmd_pkg::ch_g: return uart_cmd_pkg::st_go_addr;
			uart_cmd_pkg::ch_w: return uart_cmd_pkg::st_wr_addr;
			uart_cmd_pkg::ch_r: return uart_cmd_pkg::st_rd_start;
			uart_cmd_pkg::ch_t: return uart_cmd_pkg::st_trash;
			uart_cmd_pkg::ch_i: return uart_cmd_pkg::st_iw_addr;
			uart_cmd_pkg::ch_z: return uart_cmd_pkg::st_flush;
			default:            return uart_cmd_pkg::st_idle;
		endcase
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// one strobe cycle, then four quiet ones
	task automatic send_byte(input uart_cmd_pkg::char_t ch);
		@(negedge clk);
		rout = ch;
		rout_en = 1'b1;
		@(negedge clk);
		rout_en = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	// msb digit first, optionally with junk bytes in between
	task automatic send_word(input uart_cmd_pkg::word_t w, input logic strays);
		for (int i = 7; i >= 0; i--) begin
			send_byte(hex_char(w[i*4 +: 4]));
			if (strays && i == 5) begin
				send_byte(8'h41);
			end
			if (strays && i == 2) begin
				send_byte(8'h20);
			end
		end
	endtask

	// outputs settle between edges, the model reads them at the next rising edge
	always @(negedge clk) begin
		out_s <= {crlf_in, pc_print_sel, pc_print, inst_data_en, inst_address_set, quit_cmd,
			start_trash, read_stop, read_end_set, read_start_set, write_data_en,
			write_address_set, cpu_start};
		out_data <= uart_data;
	end

	// model follows the bytes sent and checks every output each cycle
	always @(posedge clk) begin
		logic                 quit;
		logic                 w_end;
		logic [12:0]          exp_s;
		logic [12:0]          got_s;
		uart_cmd_pkg::state_t nxt;
		if (!rst_n) begin
			m_state = uart_cmd_pkg::st_idle;
			m_en = 1'b0;
			m_cnt = 0;
			m_wv = 1'b0;
			m_data = '0;
			prev_s = '0;
		end else begin
			cyc++;
			quit = m_en && m_byte == uart_cmd_pkg::ch_q;
			nxt = m_state;
			if (quit) begin
				nxt = uart_cmd_pkg::st_idle;
			end else begin
				case (m_state)
					uart_cmd_pkg::st_idle: nxt = m_en ? idle_target(m_byte) : m_state;
					uart_cmd_pkg::st_go_addr: nxt = m_wv ? uart_cmd_pkg::st_go_run : m_state;
					uart_cmd_pkg::st_wr_addr: nxt = m_wv ? uart_cmd_pkg::st_wr_data : m_state;
					uart_cmd_pkg::st_rd_start: nxt = m_wv ? uart_cmd_pkg::st_rd_end : m_state;
					uart_cmd_pkg::st_rd_end: nxt = m_wv ? uart_cmd_pkg::st_rd_dump : m_state;
					uart_cmd_pkg::st_iw_addr: nxt = m_wv ? uart_cmd_pkg::st_iw_data : m_state;
					uart_cmd_pkg::st_rd_dump,
					uart_cmd_pkg::st_pc_print: nxt = dump_running ? m_state : uart_cmd_pkg::st_idle;
					uart_cmd_pkg::st_trash: nxt = trash_running ? m_state : uart_cmd_pkg::st_idle;
					uart_cmd_pkg::st_flush: nxt = dcflush_running ? m_state : uart_cmd_pkg::st_idle;
					default: nxt = m_state;
				endcase
			end
			// address words that close a command line
			w_end = !quit && m_wv && (m_state inside {uart_cmd_pkg::st_go_addr,
				uart_cmd_pkg::st_wr_addr, uart_cmd_pkg::st_rd_end, uart_cmd_pkg::st_iw_addr});
			exp_s[0] = (cyc == go_sample + start_delay);
			exp_s[1] = m_wv && m_state == uart_cmd_pkg::st_wr_addr;
			exp_s[2] = m_wv && m_state == uart_cmd_pkg::st_wr_data;
			exp_s[3] = m_wv && m_state == uart_cmd_pkg::st_rd_start;
			exp_s[4] = m_wv && m_state == uart_cmd_pkg::st_rd_end;
			exp_s[5] = quit && m_state == uart_cmd_pkg::st_rd_dump;
			exp_s[6] = m_en && m_byte == uart_cmd_pkg::ch_t && m_state == uart_cmd_pkg::st_idle;
			exp_s[7] = quit;
			exp_s[8] = m_wv && m_state == uart_cmd_pkg::st_iw_addr;
			exp_s[9] = m_wv && m_state == uart_cmd_pkg::st_iw_data;
			exp_s[10] = m_en && m_byte == uart_cmd_pkg::ch_j && m_state == uart_cmd_pkg::st_idle;
			exp_s[11] = m_state == uart_cmd_pkg::st_pc_print;
			exp_s[12] = w_end || quit || (m_en && (m_byte inside {uart_cmd_pkg::ch_t,
				uart_cmd_pkg::ch_j, uart_cmd_pkg::ch_z, uart_cmd_pkg::ch_cr}));
			got_s = out_s;
			for (int i = 0; i < 13; i++) begin
				compare(names[i], 32'(got_s[i]), 32'(exp_s[i]));
				pulses[i] += int'(got_s[i] & ~prev_s[i]);
			end
			compare("uart_data", out_data, m_data);
			prev_s = got_s;
			if (w_end && m_state == uart_cmd_pkg::st_go_addr) begin
				go_sample = cyc;
			end
			// word assembly, cleared when a numeric command starts
			m_wv = 1'b0;
			if (quit || (m_state == uart_cmd_pkg::st_idle && m_en
				&& (m_byte inside {uart_cmd_pkg::ch_g, uart_cmd_pkg::ch_w,
				uart_cmd_pkg::ch_r, uart_cmd_pkg::ch_i}))) begin
				m_cnt = 0;
			end else if (m_en && is_hex(m_byte) && (m_state inside {uart_cmd_pkg::st_go_addr,
				uart_cmd_pkg::st_wr_addr, uart_cmd_pkg::st_wr_data, uart_cmd_pkg::st_rd_start,
				uart_cmd_pkg::st_rd_end, uart_cmd_pkg::st_iw_addr, uart_cmd_pkg::st_iw_data})) begin
				m_chars = {m_chars[55:0], m_byte};
				m_cnt++;
				if (m_cnt == uart_cmd_pkg::hex_digits) begin
					m_wv = 1'b1;
					m_data = expected_word(m_chars);
					m_cnt = 0;
				end
			end
			m_state = nxt;
			m_en = rout_en;
			m_byte = rout;
		end
	end

	// run length follows from the byte budget
	initial begin
		#(period * (byte_budget * 5 + margin_cycles));
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int k;
		int fails;
		void'($urandom(32'h9276_4074));
		for (int i = 0; i < 13; i++) begin
			pulses[i] = 0;
		end
		rst_n = 1'b0;
		rout = '0;
		rout_en = 1'b0;
		dump_running = 1'b0;
		trash_running = 1'b0;
		dcflush_running = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// w, address, two data words, q
		send_byte(uart_cmd_pkg::ch_w);
		send_word($urandom(), 1'b0);
		send_word($urandom(), 1'b0);
		send_word($urandom(), 1'b0);
		send_byte(uart_cmd_pkg::ch_q);
		// go, cpu_start follows the address
		send_byte(uart_cmd_pkg::ch_g);
		send_word($urandom(), 1'b0);
		send_byte(uart_cmd_pkg::ch_q);
		// read range stopped by q, then one that ends on its own
		dump_running = 1'b1;
		send_byte(uart_cmd_pkg::ch_r);
		send_word($urandom(), 1'b0);
		send_word($urandom(), 1'b0);
		send_byte(uart_cmd_pkg::ch_q);
		send_byte(uart_cmd_pkg::ch_r);
		send_word($urandom(), 1'b0);
		send_word($urandom(), 1'b0);
		repeat (10) @(negedge clk);
		dump_running = 1'b0;
		// instruction write with junk between digits
		send_byte(uart_cmd_pkg::ch_i);
		send_word($urandom(), 1'b1);
		send_word($urandom(), 1'b1);
		send_byte(uart_cmd_pkg::ch_q);
		// waiting commands
		trash_running = 1'b1;
		send_byte(uart_cmd_pkg::ch_t);
		repeat (8) @(negedge clk);
		trash_running = 1'b0;
		dcflush_running = 1'b1;
		send_byte(uart_cmd_pkg::ch_z);
		// ignored while the flush runs
		send_byte(uart_cmd_pkg::ch_w);
		dcflush_running = 1'b0;
		dump_running = 1'b1;
		send_byte(uart_cmd_pkg::ch_j);
		repeat (8) @(negedge clk);
		dump_running = 1'b0;
		k = 0;
		while (pc_print_sel && k < 10) begin
			@(negedge clk);
			k++;
		end
		if (pc_print_sel) begin
			errors++;
			$display("pc_print_sel stayed high after dump_running fell");
		end
		send_byte(uart_cmd_pkg::ch_cr);
		repeat (10) @(negedge clk);
		for (int i = 0; i < 13; i++) begin
			compare({"pulses of ", names[i]}, 32'(pulses[i]), 32'(expected_pulses[i]));
		end
		fails = u_dut.u_fsm.u_checker.failures;
		$display("Checks done: %0d mismatches, %0d assertion failures", errors, fails);
		if (errors == 0 && fails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tb/uart_cmd_checker.sv ====
// command fsm assertions
`timescale 1ns/1ps

module uart_cmd_checker #(
	parameter int unsigned start_delay = 3
) (
	input logic                 clk,
	input logic                 rst_n,
	input uart_cmd_pkg::state_t state,
	input uart_cmd_pkg::cmd_t   cmd,
	input logic                 word_valid,
	input logic                 crlf_in,
	input logic                 cpu_start,
	// all control strobes except cpu_start
	input logic [10:0]          strobes
);

	// failed assertions, summed into the testbench result
	int failures = 0;

	// strobes never last past one cycle
	a_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		(|strobes) |=> (strobes == '0))
	else begin
		failures++;
		$error("control strobe stayed high for more than one cycle");
	end

	// cpu starts a fixed time after the go address line break
	a_go_start: assert property (@(posedge clk) disable iff (!rst_n)
		(state == uart_cmd_pkg::st_go_addr && word_valid && crlf_in)
		|-> ##start_delay cpu_start)
	else begin
		failures++;
		$error("cpu_start did not follow the go address by start_delay cycles");
	end

	// q always lands in idle
	a_quit_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd == uart_cmd_pkg::cmd_quit) |=> (state == uart_cmd_pkg::st_idle))
	else begin
		failures++;
		$error("parser did not return to idle after quit");
	end

endmodule

// ==== src/uart_cmd_top.sv ====
// uart debug monitor command parser
`timescale 1ns/1ps

module uart_cmd_top #(
	parameter int unsigned start_delay = 3
) (
	input  logic                clk,
	input  logic                rst_n,
	// deframed bytes from the uart receiver
	input  uart_cmd_pkg::char_t rout,
	input  logic                rout_en,
	// busy levels from the control logic
	input  logic                dump_running,
	input  logic                trash_running,
	input  logic                dcflush_running,
	// to the control logic
	output uart_cmd_pkg::word_t uart_data,
	output logic                cpu_start,
	output logic                write_address_set,
	output logic                write_data_en,
	output logic                read_start_set,
	output logic                read_end_set,
	output logic                read_stop,
	output logic                start_trash,
	output logic                quit_cmd,
	output logic                inst_address_set,
	output logic                inst_data_en,
	output logic                pc_print,
	output logic                pc_print_sel,
	output logic                crlf_in
);

	// decoder outputs
	logic                  digit_valid;
	uart_cmd_pkg::nibble_t nibble;
	uart_cmd_pkg::cmd_t    cmd;
	// assembler handshake with the fsm
	logic                  collect;
	logic                  word_clear;
	logic                  word_valid;

	uart_char_decoder u_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.rout        (rout),
		.rout_en     (rout_en),
		.digit_valid (digit_valid),
		.nibble      (nibble),
		.cmd         (cmd)
	);

	hex_word_assembler u_assembler (
		.clk         (clk),
		.rst_n       (rst_n),
		.digit_valid (digit_valid),
		.nibble      (nibble),
		.collect     (collect),
		.word_clear  (word_clear),
		.word_valid  (word_valid),
		.uart_data   (uart_data)
	);

	monitor_cmd_fsm #(
		.start_delay (start_delay)
	) u_fsm (
		.clk               (clk),
		.rst_n             (rst_n),
		.cmd               (cmd),
		.word_valid        (word_valid),
		.dump_running      (dump_running),
		.trash_running     (trash_running),
		.dcflush_running   (dcflush_running),
		.collect           (collect),
		.word_clear        (word_clear),
		.cpu_start         (cpu_start),
		.write_address_set (write_address_set),
		.write_data_en     (write_data_en),
		.read_start_set    (read_start_set),
		.read_end_set      (read_end_set),
		.read_stop         (read_stop),
		.start_trash       (start_trash),
		.quit_cmd          (quit_cmd),
		.inst_address_set  (inst_address_set),
		.inst_data_en      (inst_data_en),
		.pc_print          (pc_print),
		.pc_print_sel      (pc_print_sel),
		.crlf_in           (crlf_in)
	);

endmodule

// ==== src/monitor_cmd_fsm.sv ====
// monitor command state machine
`timescale 1ns/1ps

module monitor_cmd_fsm #(
	parameter int unsigned start_delay = 3
) (
	input  logic               clk,
	input  logic               rst_n,
	input  uart_cmd_pkg::cmd_t cmd,
	input  logic               word_valid,
	input  logic               dump_running,
	input  logic               trash_running,
	input  logic               dcflush_running,
	output logic               collect,
	output logic               word_clear,
	output logic               cpu_start,
	output logic               write_address_set,
	output logic               write_data_en,
	output logic               read_start_set,
	output logic               read_end_set,
	output logic               read_stop,
	output logic               start_trash,
	output logic               quit_cmd,
	output logic               inst_address_set,
	output logic               inst_data_en,
	output logic               pc_print,
	output logic               pc_print_sel,
	output logic               crlf_in
);

	uart_cmd_pkg::state_t   state;
	uart_cmd_pkg::state_t   next_state;
	logic                   is_quit;
	logic                   is_idle;
	logic                   word_start;
	// word-ending transitions
	logic                   g_end;
	logic                   w_end;
	logic                   r_end;
	logic                   i_end;
	// delay line from the g address crlf to cpu_start
	logic [start_delay-1:0] start_chain;

	assign is_quit = (cmd == uart_cmd_pkg::cmd_quit);
	assign is_idle = (state == uart_cmd_pkg::st_idle);

	always_comb begin
		next_state = state;
		if (is_quit) begin
			// q aborts any command
			next_state = uart_cmd_pkg::st_idle;
		end else begin
			case (state)
				uart_cmd_pkg::st_idle: begin
					// one letter per cycle, order follows the j g w r t i z priority
					case (cmd)
						uart_cmd_pkg::cmd_pc:     next_state = uart_cmd_pkg::st_pc_print;
						uart_cmd_pkg::cmd_go:     next_state = uart_cmd_pkg::st_go_addr;
						uart_cmd_pkg::cmd_write:  next_state = uart_cmd_pkg::st_wr_addr;
						uart_cmd_pkg::cmd_read:   next_state = uart_cmd_pkg::st_rd_start;
						uart_cmd_pkg::cmd_trash:  next_state = uart_cmd_pkg::st_trash;
						uart_cmd_pkg::cmd_iwrite: next_state = uart_cmd_pkg::st_iw_addr;
						uart_cmd_pkg::cmd_flush:  next_state = uart_cmd_pkg::st_flush;
						default:                  next_state = uart_cmd_pkg::st_idle;
					endcase
				end
				// address states move on with each finished word
				uart_cmd_pkg::st_go_addr: begin
					if (word_valid) begin
						next_state = uart_cmd_pkg::st_go_run;
					end
				end
				uart_cmd_pkg::st_wr_addr: begin
					if (word_valid) begin
						next_state = uart_cmd_pkg::st_wr_data;
					end
				end
				uart_cmd_pkg::st_rd_start: begin
					if (word_valid) begin
						next_state = uart_cmd_pkg::st_rd_end;
					end
				end
				uart_cmd_pkg::st_rd_end: begin
					if (word_valid) begin
						next_state = uart_cmd_pkg::st_rd_dump;
					end
				end
				uart_cmd_pkg::st_iw_addr: begin
					if (word_valid) begin
						next_state = uart_cmd_pkg::st_iw_data;
					end
				end
				// run and data states hold until q
				uart_cmd_pkg::st_go_run,
				uart_cmd_pkg::st_wr_data,
				uart_cmd_pkg::st_iw_data: next_state = state;
				// waiting states end once the control logic goes quiet
				uart_cmd_pkg::st_rd_dump: begin
					if (!dump_running) begin
						next_state = uart_cmd_pkg::st_idle;
					end
				end
				uart_cmd_pkg::st_trash: begin
					if (!trash_running) begin
						next_state = uart_cmd_pkg::st_idle;
					end
				end
				uart_cmd_pkg::st_pc_print: begin
					// pc printing shares the dump busy flag
					if (!dump_running) begin
						next_state = uart_cmd_pkg::st_idle;
					end
				end
				uart_cmd_pkg::st_flush: begin
					if (!dcflush_running) begin
						next_state = uart_cmd_pkg::st_idle;
					end
				end
				default: next_state = uart_cmd_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= uart_cmd_pkg::st_idle;
		end else begin
			state <= next_state;
		end
	end

	// digits only count in number-gathering states
	assign collect = state inside {
		uart_cmd_pkg::st_go_addr, uart_cmd_pkg::st_wr_addr, uart_cmd_pkg::st_wr_data,
		uart_cmd_pkg::st_rd_start, uart_cmd_pkg::st_rd_end,
		uart_cmd_pkg::st_iw_addr, uart_cmd_pkg::st_iw_data
	};

	// fresh word for every numeric command
	assign word_start = is_idle & (cmd inside {
		uart_cmd_pkg::cmd_go, uart_cmd_pkg::cmd_write,
		uart_cmd_pkg::cmd_read, uart_cmd_pkg::cmd_iwrite
	});
	assign word_clear = word_start | is_quit;

	assign g_end = (state == uart_cmd_pkg::st_go_addr) & (next_state == uart_cmd_pkg::st_go_run);
	assign w_end = (state == uart_cmd_pkg::st_wr_addr) & (next_state == uart_cmd_pkg::st_wr_data);
	assign r_end = (state == uart_cmd_pkg::st_rd_end) & (next_state == uart_cmd_pkg::st_rd_dump);
	assign i_end = (state == uart_cmd_pkg::st_iw_addr) & (next_state == uart_cmd_pkg::st_iw_data);

	// strobes to memory and cpu control
	assign write_address_set = (state == uart_cmd_pkg::st_wr_addr) & word_valid;
	assign write_data_en     = (state == uart_cmd_pkg::st_wr_data) & word_valid;
	assign read_start_set    = (state == uart_cmd_pkg::st_rd_start) & word_valid;
	assign read_end_set      = (state == uart_cmd_pkg::st_rd_end) & word_valid;
	assign inst_address_set  = (state == uart_cmd_pkg::st_iw_addr) & word_valid;
	assign inst_data_en      = (state == uart_cmd_pkg::st_iw_data) & word_valid;
	// only a quit during the dump stops the reader
	assign read_stop   = (state == uart_cmd_pkg::st_rd_dump) & is_quit;
	assign start_trash = is_idle & (cmd == uart_cmd_pkg::cmd_trash);
	assign quit_cmd    = is_quit;
	assign pc_print    = is_idle & (cmd == uart_cmd_pkg::cmd_pc);
	assign pc_print_sel = (state == uart_cmd_pkg::st_pc_print);

	// line break for the terminal
	assign crlf_in = g_end | w_end | r_end | i_end | is_quit
		| (cmd == uart_cmd_pkg::cmd_trash) | (cmd == uart_cmd_pkg::cmd_pc)
		| (cmd == uart_cmd_pkg::cmd_flush) | (cmd == uart_cmd_pkg::cmd_cr);

	// start the cpu a few cycles after the go address is taken
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_chain <= '0;
		end else begin
			start_chain <= start_delay'({start_chain, g_end});
		end
	end

	assign cpu_start = start_chain[start_delay-1];

endmodule

// ==== src/hex_word_assembler.sv ====
// hex digit to word assembler
`timescale 1ns/1ps

module hex_word_assembler (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  digit_valid,
	input  uart_cmd_pkg::nibble_t nibble,
	input  logic                  collect,
	input  logic                  word_clear,
	output logic                  word_valid,
	output uart_cmd_pkg::word_t   uart_data
);

	// partial word, newest digit at the low end
	uart_cmd_pkg::word_t      word_sr;
	uart_cmd_pkg::word_t      word_next;
	uart_cmd_pkg::digit_cnt_t digit_cnt;
	logic                     shift_en;
	logic                     last_digit;

	assign shift_en = digit_valid & collect;
	assign last_digit = shift_en
		& (digit_cnt == uart_cmd_pkg::digit_cnt_t'(uart_cmd_pkg::hex_digits - 1));
	// oldest nibble drops off the top
	assign word_next = uart_cmd_pkg::word_t'({word_sr, nibble});

	always_ff @(posedge clk) begin
		if (word_clear) begin
			word_sr <= '0;
		end else if (shift_en) begin
			word_sr <= word_next;
		end
	end

	// counter wraps straight back to zero after the last digit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_cnt <= '0;
		end else if (word_clear) begin
			digit_cnt <= '0;
		end else if (last_digit) begin
			digit_cnt <= '0;
		end else if (shift_en) begin
			digit_cnt <= digit_cnt + 1'b1;
		end
	end

	// completed word and its one-cycle flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word_valid <= 1'b0;
			uart_data  <= '0;
		end else begin
			word_valid <= last_digit;
			if (last_digit) begin
				uart_data <= word_next;
			end
		end
	end

endmodule

// ==== src/uart_char_decoder.sv ====
// received character decoder
`timescale 1ns/1ps

module uart_char_decoder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  uart_cmd_pkg::char_t   rout,
	input  logic                  rout_en,
	output logic                  digit_valid,
	output uart_cmd_pkg::nibble_t nibble,
	output uart_cmd_pkg::cmd_t    cmd
);

	// byte captured on the receiver strobe
	uart_cmd_pkg::char_t   pdata;
	// strobe delayed to line up with pdata
	logic                  data_en;
	// classification of the held byte
	logic                  hex_hit;
	uart_cmd_pkg::nibble_t hex_val;
	uart_cmd_pkg::cmd_t    cmd_dec;

	always_ff @(posedge clk) begin
		if (rout_en) begin
			pdata <= rout;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_en <= 1'b0;
		end else begin
			data_en <= rout_en;
		end
	end

	// lower case hex only, upper case falls through
	always_comb begin
		hex_hit = 1'b0;
		hex_val = '0;
		if (pdata >= uart_cmd_pkg::ch_zero && pdata <= uart_cmd_pkg::ch_nine) begin
			hex_hit = 1'b1;
			hex_val = uart_cmd_pkg::nibble_t'(pdata - uart_cmd_pkg::ch_zero);
		end else if (pdata >= uart_cmd_pkg::ch_a_low && pdata <= uart_cmd_pkg::ch_f_low) begin
			hex_hit = 1'b1;
			// 'a' maps to ten
			hex_val = uart_cmd_pkg::nibble_t'(pdata - uart_cmd_pkg::ch_a_low + 8'd10);
		end
	end

	// command letters and carriage return
	always_comb begin
		case (pdata)
			uart_cmd_pkg::ch_g:  cmd_dec = uart_cmd_pkg::cmd_go;
			uart_cmd_pkg::ch_q:  cmd_dec = uart_cmd_pkg::cmd_quit;
			uart_cmd_pkg::ch_w:  cmd_dec = uart_cmd_pkg::cmd_write;
			uart_cmd_pkg::ch_r:  cmd_dec = uart_cmd_pkg::cmd_read;
			uart_cmd_pkg::ch_t:  cmd_dec = uart_cmd_pkg::cmd_trash;
			uart_cmd_pkg::ch_i:  cmd_dec = uart_cmd_pkg::cmd_iwrite;
			uart_cmd_pkg::ch_j:  cmd_dec = uart_cmd_pkg::cmd_pc;
			uart_cmd_pkg::ch_z:  cmd_dec = uart_cmd_pkg::cmd_flush;
			uart_cmd_pkg::ch_cr: cmd_dec = uart_cmd_pkg::cmd_cr;
			default:             cmd_dec = uart_cmd_pkg::cmd_none;
		endcase
	end

	// valid only in the cycle after the byte arrives
	assign digit_valid = data_en & hex_hit;
	// nibble is qualified by digit_valid downstream
	assign nibble = hex_val;
	assign cmd = data_en ? cmd_dec : uart_cmd_pkg::cmd_none;

endmodule

// ==== src/uart_cmd_pkg.sv ====
// uart monitor command parser definitions
package uart_cmd_pkg;

	// one byte as delivered by the uart receiver
	typedef logic [7:0] char_t;

	// value of a single hex digit
	typedef logic [3:0] nibble_t;

	// assembled address or data word
	typedef logic [31:0] word_t;

	// digits per word, msb first on the line
	localparam int hex_digits = 8;

	// digit position inside a word
	typedef logic [2:0] digit_cnt_t;

	// decoded command letters, valid for one cycle only
	typedef enum logic [3:0] {
		cmd_none,
		cmd_go,
		cmd_quit,
		cmd_write,
		cmd_read,
		cmd_trash,
		cmd_iwrite,
		cmd_pc,
		cmd_flush,
		cmd_cr
	} cmd_t;

	// parser states
	typedef enum logic [4:0] {
		st_idle,
		// g <addr>
		st_go_addr,
		st_go_run,
		// w <addr> <data> ... q
		st_wr_addr,
		st_wr_data,
		// r <start> <end>, then dump
		st_rd_start,
		st_rd_end,
		st_rd_dump,
		// t, wait for clear to finish
		st_trash,
		// i <addr> <data> ... q
		st_iw_addr,
		st_iw_data,
		// j, pc is being printed
		st_pc_print,
		// z, d-cache flush in progress
		st_flush
	} state_t;

	// ascii codes seen by the decoder
	localparam char_t ch_zero  = 8'h30;
	localparam char_t ch_nine  = 8'h39;
	localparam char_t ch_a_low = 8'h61;
	localparam char_t ch_f_low = 8'h66;
	localparam char_t ch_g     = 8'h67;
	localparam char_t ch_q     = 8'h71;
	localparam char_t ch_w     = 8'h77;
	localparam char_t ch_r     = 8'h72;
	localparam char_t ch_t     = 8'h74;
	localparam char_t ch_i     = 8'h69;
	localparam char_t ch_j     = 8'h6a;
	localparam char_t ch_z     = 8'h7a;
	localparam char_t ch_cr    = 8'h0d;

endpackage
